// ==== Makefile ====
# Verilator build and run for the remote-load trace monitor

SIM = obj_dir/sim

all: run

$(SIM): files.f hw/*.sv testbench/*.sv
	verilator --binary --timing --assert -f files.f --top-module tb_rl_trace \
		-Mdir obj_dir -o sim

run: $(SIM)
	-./$(SIM) | tee sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -f files.f --top-module rl_trace_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== files.f ====
hw/rl_trace_pkg.sv
hw/rl_trace_if.sv
hw/rl_req_classify.sv
hw/rl_status_table.sv
hw/rl_trace_axil.sv
hw/rl_trace_top.sv
testbench/tb_rl_trace.sv

// ==== hw/rl_req_classify.sv ====
// Outgoing packet classifier
// turns each valid packet into a launch event of class int, float, icache or store
`timescale 1ns/100ps
`default_nettype none

module rl_req_classify (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,
  input  wire logic                                out_v_i,
  input  wire logic [rl_trace_pkg::RL_OP_W-1:0]     out_op_i,
  input  wire logic [rl_trace_pkg::RL_REG_ID_W-1:0] out_reg_id_i,
  input  wire logic [rl_trace_pkg::RL_X_W-1:0]      out_x_i,
  input  wire logic [rl_trace_pkg::RL_Y_W-1:0]      out_y_i,
  input  wire rl_trace_pkg::rl_payload_u           out_payload_i,
  rl_launch_if.driver                              launch
);
  import rl_trace_pkg::*;

  logic is_load;
  logic icache_fetch;
  logic float_wb;

  assign is_load      = (out_op_i == RL_OP_LOAD);
  assign icache_fetch = out_payload_i.load_info.icache_fetch;
  assign float_wb     = out_payload_i.load_info.float_wb;

  // icache wins over float, amo is tracked as an int load
  always_comb begin
    launch.kind = RL_TYPE_INT;
    if (is_load && icache_fetch) begin
      launch.kind = RL_TYPE_ICACHE;
    end else if (is_load && float_wb) begin
      launch.kind = RL_TYPE_FLOAT;
    end else if (out_op_i == RL_OP_STORE || out_op_i == RL_OP_SW) begin
      launch.kind = RL_TYPE_STORE;
    end
  end

  // every op maps to some class
  assign launch.v      = out_v_i;
  assign launch.reg_id = out_reg_id_i;
  assign launch.x      = out_x_i;
  assign launch.y      = out_y_i;

  // the core never asks for an icache line with a float writeback
  a_load_info_onehot: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (out_v_i && is_load) |-> !(icache_fetch && float_wb)
  );

endmodule

`default_nettype wire

// ==== hw/rl_status_table.sv ====
// Remote-load status table
// stamps each load launch per class and register, and emits a trace record when
// the response is accepted; stores are recorded at departure with zero latency
`timescale 1ns/100ps
`default_nettype none

module rl_status_table (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,
  rl_launch_if.monitor                             launch,
  input  wire logic                                returned_v_i,
  input  wire logic                                returned_yumi_i,
  input  wire logic [rl_trace_pkg::RL_REG_ID_W-1:0] returned_reg_id_i,
  input  wire logic [rl_trace_pkg::RL_RET_W-1:0]    returned_type_i,
  input  wire logic                                trace_en_i,
  input  wire logic [rl_trace_pkg::RL_CTR_W-1:0]    global_ctr_i,
  rl_record_if.source                              rec
);
  import rl_trace_pkg::*;

  // slot state, index 0..31 int, 32..63 float, 64 icache
  logic [RL_CTR_W-1:0]    start_r [RL_SLOT_ELS];
  logic [RL_X_W-1:0]      x_r     [RL_SLOT_ELS];
  logic [RL_Y_W-1:0]      y_r     [RL_SLOT_ELS];
  logic [RL_SLOT_ELS-1:0] out_r;

  logic                 load_v;
  logic                 store_v;
  logic                 ret_fire;
  logic [RL_SLOT_W-1:0] launch_idx;
  logic [RL_SLOT_W-1:0] ret_idx;
  logic [RL_TYPE_W-1:0] ret_kind;

  // store waiting behind a return record pushed in the same cycle
  logic                   pend_v_r;
  logic [RL_REG_ID_W-1:0] pend_reg_r;
  logic [RL_X_W-1:0]      pend_x_r;
  logic [RL_Y_W-1:0]      pend_y_r;
  logic [RL_CTR_W-1:0]    pend_start_r;

  assign load_v   = launch.v && (launch.kind != RL_TYPE_STORE);
  assign store_v  = launch.v && (launch.kind == RL_TYPE_STORE) && trace_en_i;
  assign ret_fire = returned_v_i && returned_yumi_i && (returned_type_i != RL_RET_NONE);

  always_comb begin
    case (launch.kind)
      RL_TYPE_FLOAT:  launch_idx = {2'b01, launch.reg_id};
      RL_TYPE_ICACHE: launch_idx = RL_SLOT_W'(2 * RL_REG_ELS);
      default:        launch_idx = {2'b00, launch.reg_id};
    endcase
    case (returned_type_i)
      RL_RET_FLOAT: begin
        ret_idx  = {2'b01, returned_reg_id_i};
        ret_kind = RL_TYPE_FLOAT;
      end
      RL_RET_IFETCH: begin
        ret_idx  = RL_SLOT_W'(2 * RL_REG_ELS);
        ret_kind = RL_TYPE_ICACHE;
      end
      default: begin
        ret_idx  = {2'b00, returned_reg_id_i};
        ret_kind = RL_TYPE_INT;
      end
    endcase
  end

  // stamping runs whether or not tracing is enabled
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < RL_SLOT_ELS; i++) begin
        start_r[i] <= '0;
        x_r[i]     <= '0;
        y_r[i]     <= '0;
      end
      out_r <= '0;
    end else begin
      if (ret_fire) begin
        out_r[ret_idx] <= 1'b0;
      end
      // a new launch to the slot just returned takes the slot again
      if (load_v) begin
        start_r[launch_idx] <= global_ctr_i;
        x_r[launch_idx]     <= launch.x;
        y_r[launch_idx]     <= launch.y;
        out_r[launch_idx]   <= 1'b1;
      end
    end
  end

  // push priority is return, then pending store, then new store
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rec.v    <= 1'b0;
      pend_v_r <= 1'b0;
    end else begin
      rec.v <= trace_en_i && (ret_fire || pend_v_r || store_v);
      if (store_v && (ret_fire || pend_v_r)) begin
        pend_v_r <= 1'b1;
      end else if (trace_en_i && !ret_fire) begin
        pend_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ret_fire) begin
      rec.kind    <= ret_kind;
      rec.reg_id  <= returned_reg_id_i;
      rec.x       <= x_r[ret_idx];
      rec.y       <= y_r[ret_idx];
      rec.start   <= start_r[ret_idx];
      rec.latency <= global_ctr_i - start_r[ret_idx];
    end else if (pend_v_r) begin
      rec.kind    <= RL_TYPE_STORE;
      rec.reg_id  <= pend_reg_r;
      rec.x       <= pend_x_r;
      rec.y       <= pend_y_r;
      rec.start   <= pend_start_r;
      rec.latency <= '0;
    end else begin
      rec.kind    <= RL_TYPE_STORE;
      rec.reg_id  <= launch.reg_id;
      rec.x       <= launch.x;
      rec.y       <= launch.y;
      rec.start   <= global_ctr_i;
      rec.latency <= '0;
    end
    if (store_v && (ret_fire || pend_v_r)) begin
      pend_reg_r   <= launch.reg_id;
      pend_x_r     <= launch.x;
      pend_y_r     <= launch.y;
      pend_start_r <= global_ctr_i;
    end
  end

  // a register writeback is only ever returned for a load that was sent
  a_ret_hits_slot: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (returned_v_i && returned_yumi_i &&
     (returned_type_i == RL_RET_INT || returned_type_i == RL_RET_FLOAT))
    |-> out_r[ret_idx]
  );

endmodule

`default_nettype wire

// ==== hw/rl_trace_axil.sv ====
// Trace record FIFO with AXI4-Lite host access
// records are dropped and counted when the FIFO is full, an info read pops the head
`timescale 1ns/100ps
`default_nettype none

module rl_trace_axil (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset_i,
  rl_record_if.sink                                  rec,
  input  wire logic [rl_trace_pkg::RL_AXI_ADDR_W-1:0] s_awaddr_i,
  input  wire logic                                  s_awvalid_i,
  output logic                                       s_awready_o,
  input  wire logic [31:0]                           s_wdata_i,
  input  wire logic                                  s_wvalid_i,
  output logic                                       s_wready_o,
  output logic [1:0]                                 s_bresp_o,
  output logic                                       s_bvalid_o,
  input  wire logic                                  s_bready_i,
  input  wire logic [rl_trace_pkg::RL_AXI_ADDR_W-1:0] s_araddr_i,
  input  wire logic                                  s_arvalid_i,
  output logic                                       s_arready_o,
  output logic [31:0]                                s_rdata_o,
  output logic [1:0]                                 s_rresp_o,
  output logic                                       s_rvalid_o,
  input  wire logic                                  s_rready_i
);
  import rl_trace_pkg::*;

  // FIFO storage, one start, latency and info word per record
  logic [31:0] start_mem [RL_FIFO_DEPTH];
  logic [31:0] lat_mem   [RL_FIFO_DEPTH];
  logic [31:0] info_mem  [RL_FIFO_DEPTH];

  logic [RL_FIFO_PTR_W-1:0] wr_ptr_r;
  logic [RL_FIFO_PTR_W-1:0] rd_ptr_r;
  logic [RL_FIFO_CNT_W-1:0] count_r;
  logic [RL_DROP_W-1:0]     drop_r;

  logic        full;
  logic        empty;
  logic        push;
  logic        pop;
  logic        ar_fire;
  logic        aw_fire;
  logic [31:0] rd_word;

  assign full    = (count_r == RL_FIFO_CNT_W'(RL_FIFO_DEPTH));
  assign empty   = (count_r == '0);
  assign push    = rec.v && !full;
  assign ar_fire = s_arvalid_i && s_arready_o;
  assign pop     = ar_fire && (s_araddr_i == RL_REG_INFO) && !empty;
  // write data is ignored, any write to status clears the drop count
  assign aw_fire = s_awvalid_i && s_wvalid_i && !s_bvalid_o;

  assign s_arready_o = !s_rvalid_o;
  assign s_awready_o = !s_bvalid_o;
  assign s_wready_o  = !s_bvalid_o;
  assign s_bresp_o   = 2'b00;
  assign s_rresp_o   = 2'b00;

  always_ff @(posedge clk_i) begin
    if (push) begin
      start_mem[wr_ptr_r] <= rec.start;
      lat_mem[wr_ptr_r]   <= rec.latency;
      info_mem[wr_ptr_r]  <= {11'b0, rec.y, 2'b0, rec.x, 1'b0, rec.reg_id, rec.kind};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      drop_r   <= '0;
    end else begin
      wr_ptr_r <= wr_ptr_r + RL_FIFO_PTR_W'(push);
      rd_ptr_r <= rd_ptr_r + RL_FIFO_PTR_W'(pop);
      count_r  <= count_r + RL_FIFO_CNT_W'(push) - RL_FIFO_CNT_W'(pop);
      if (aw_fire && s_awaddr_i == RL_REG_STATUS) begin
        drop_r <= '0;
      end else if (rec.v && full && drop_r != '1) begin
        drop_r <= drop_r + 1'b1;
      end
    end
  end

  // record words read as zero while the FIFO is empty
  always_comb begin
    rd_word = '0;
    case (s_araddr_i)
      RL_REG_STATUS:  rd_word = {drop_r, 11'b0, count_r};
      RL_REG_START:   rd_word = empty ? '0 : start_mem[rd_ptr_r];
      RL_REG_LATENCY: rd_word = empty ? '0 : lat_mem[rd_ptr_r];
      RL_REG_INFO:    rd_word = empty ? '0 : info_mem[rd_ptr_r];
      default:        rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s_rvalid_o <= 1'b0;
      s_bvalid_o <= 1'b0;
    end else begin
      if (ar_fire) begin
        s_rvalid_o <= 1'b1;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
      if (aw_fire) begin
        s_bvalid_o <= 1'b1;
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      s_rdata_o <= rd_word;
    end
  end

  // read data is held while the host stalls the response
  a_rvalid_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (s_rvalid_o && !s_rready_i) |=> (s_rvalid_o && $stable(s_rdata_o))
  );

endmodule

`default_nettype wire

// ==== hw/rl_trace_if.sv ====
// Interfaces between the trace blocks
// launch events from the classifier and finished records into the host FIFO
`timescale 1ns/100ps
`default_nettype none

interface rl_launch_if ();
  import rl_trace_pkg::*;

  logic                   v;
  logic [RL_TYPE_W-1:0]   kind;
  logic [RL_REG_ID_W-1:0] reg_id;
  logic [RL_X_W-1:0]      x;
  logic [RL_Y_W-1:0]      y;

  // observe only, no handshake
  modport driver  (output v, kind, reg_id, x, y);
  modport monitor (input  v, kind, reg_id, x, y);
endinterface

interface rl_record_if ();
  import rl_trace_pkg::*;

  logic                   v;
  logic [RL_TYPE_W-1:0]   kind;
  logic [RL_REG_ID_W-1:0] reg_id;
  logic [RL_X_W-1:0]      x;
  logic [RL_Y_W-1:0]      y;
  logic [RL_CTR_W-1:0]    start;
  logic [RL_CTR_W-1:0]    latency;

  // v is a one-cycle push, the sink never pushes back
  modport source (output v, kind, reg_id, x, y, start, latency);
  modport sink   (input  v, kind, reg_id, x, y, start, latency);
endinterface

`default_nettype wire

// ==== hw/rl_trace_pkg.sv ====
// Remote-load trace package
// field widths, packet and return codes, record types and host register map
`default_nettype none

package rl_trace_pkg;

  // register id and slot table
  localparam int RL_REG_ID_W = 5;
  localparam int RL_REG_ELS  = 1 << RL_REG_ID_W;
  // int slots, then float slots, then the single icache slot
  localparam int RL_SLOT_ELS = 2 * RL_REG_ELS + 1;
  localparam int RL_SLOT_W   = $clog2(RL_SLOT_ELS);

  // destination coordinates and cycle counter
  localparam int RL_X_W   = 6;
  localparam int RL_Y_W   = 5;
  localparam int RL_CTR_W = 32;

  // outgoing packet op
  localparam int RL_OP_W = 2;
  localparam logic [RL_OP_W-1:0] RL_OP_LOAD  = 2'd0;
  localparam logic [RL_OP_W-1:0] RL_OP_STORE = 2'd1;
  localparam logic [RL_OP_W-1:0] RL_OP_SW    = 2'd2;
  localparam logic [RL_OP_W-1:0] RL_OP_AMO   = 2'd3;

  // returned packet type
  localparam int RL_RET_W = 2;
  localparam logic [RL_RET_W-1:0] RL_RET_INT    = 2'd0;
  localparam logic [RL_RET_W-1:0] RL_RET_FLOAT  = 2'd1;
  localparam logic [RL_RET_W-1:0] RL_RET_IFETCH = 2'd2;
  localparam logic [RL_RET_W-1:0] RL_RET_NONE   = 2'd3;

  // trace record type
  localparam int RL_TYPE_W = 2;
  localparam logic [RL_TYPE_W-1:0] RL_TYPE_INT    = 2'd0;
  localparam logic [RL_TYPE_W-1:0] RL_TYPE_FLOAT  = 2'd1;
  localparam logic [RL_TYPE_W-1:0] RL_TYPE_ICACHE = 2'd2;
  localparam logic [RL_TYPE_W-1:0] RL_TYPE_STORE  = 2'd3;

  // record FIFO and drop counter
  localparam int RL_FIFO_DEPTH = 16;
  localparam int RL_FIFO_PTR_W = $clog2(RL_FIFO_DEPTH);
  localparam int RL_FIFO_CNT_W = RL_FIFO_PTR_W + 1;
  localparam int RL_DROP_W     = 16;

  // AXI4-Lite byte offsets
  localparam int RL_AXI_ADDR_W = 4;
  localparam logic [RL_AXI_ADDR_W-1:0] RL_REG_STATUS  = 4'h0;
  localparam logic [RL_AXI_ADDR_W-1:0] RL_REG_START   = 4'h4;
  localparam logic [RL_AXI_ADDR_W-1:0] RL_REG_LATENCY = 4'h8;
  localparam logic [RL_AXI_ADDR_W-1:0] RL_REG_INFO    = 4'hC;

  // payload word, read as load info on loads and as data on stores
  typedef union packed {
    logic [31:0] store_data;
    struct packed {
      logic [29:0] reserved;
      logic        float_wb;
      logic        icache_fetch;
    } load_info;
  } rl_payload_u;

endpackage

`default_nettype wire

// ==== hw/rl_trace_top.sv ====
// Remote-load latency monitor for one tile
// classifier, status table and host-readable record FIFO behind AXI4-Lite
`timescale 1ns/100ps
`default_nettype none

module rl_trace_top (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset_i,
  // outgoing packets
  input  wire logic                                  out_v_i,
  input  wire logic [rl_trace_pkg::RL_OP_W-1:0]       out_op_i,
  input  wire logic [rl_trace_pkg::RL_REG_ID_W-1:0]   out_reg_id_i,
  input  wire logic [rl_trace_pkg::RL_X_W-1:0]        out_x_i,
  input  wire logic [rl_trace_pkg::RL_Y_W-1:0]        out_y_i,
  input  wire logic [31:0]                           out_payload_i,
  // load responses
  input  wire logic                                  returned_v_i,
  input  wire logic                                  returned_yumi_i,
  input  wire logic [rl_trace_pkg::RL_REG_ID_W-1:0]   returned_reg_id_i,
  input  wire logic [rl_trace_pkg::RL_RET_W-1:0]      returned_type_i,
  // control
  input  wire logic                                  trace_en_i,
  input  wire logic [rl_trace_pkg::RL_CTR_W-1:0]      global_ctr_i,
  // AXI4-Lite slave
  input  wire logic [rl_trace_pkg::RL_AXI_ADDR_W-1:0] s_awaddr_i,
  input  wire logic                                  s_awvalid_i,
  output logic                                       s_awready_o,
  input  wire logic [31:0]                           s_wdata_i,
  input  wire logic                                  s_wvalid_i,
  output logic                                       s_wready_o,
  output logic [1:0]                                 s_bresp_o,
  output logic                                       s_bvalid_o,
  input  wire logic                                  s_bready_i,
  input  wire logic [rl_trace_pkg::RL_AXI_ADDR_W-1:0] s_araddr_i,
  input  wire logic                                  s_arvalid_i,
  output logic                                       s_arready_o,
  output logic [31:0]                                s_rdata_o,
  output logic [1:0]                                 s_rresp_o,
  output logic                                       s_rvalid_o,
  input  wire logic                                  s_rready_i
);

  rl_launch_if launch ();
  rl_record_if rec ();

  rl_req_classify classify0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .out_v_i       (out_v_i),
    .out_op_i      (out_op_i),
    .out_reg_id_i  (out_reg_id_i),
    .out_x_i       (out_x_i),
    .out_y_i       (out_y_i),
    .out_payload_i (out_payload_i),
    .launch        (launch.driver)
  );

  rl_status_table table0 (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .launch            (launch.monitor),
    .returned_v_i      (returned_v_i),
    .returned_yumi_i   (returned_yumi_i),
    .returned_reg_id_i (returned_reg_id_i),
    .returned_type_i   (returned_type_i),
    .trace_en_i        (trace_en_i),
    .global_ctr_i      (global_ctr_i),
    .rec               (rec.source)
  );

  rl_trace_axil axil0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rec         (rec.sink),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i)
  );

endmodule

`default_nettype wire

// ==== testbench/rl_trace_testdata.txt ====
# L op reg x y view(i|d) value | R type reg | W cycles | T trace_en | H hold cycles
# E kind reg x y latency | S drops count | C clear drops | Z empty read | F stores | K drain stores
T 1
L 0 3 5 2 i 0
W 2
L 0 3 7 4 i 2
W 1
L 0 3 9 1 i 1
W 1
L 3 4 2 2 d 0
W 3
R 1 3
W 2
R 2 3
W 1
R 0 3
W 1
R 0 4
W 2
E 1 3 7 4 5
E 2 3 9 1 6
E 0 3 5 2 10
E 0 4 2 2 7
L 0 8 1 1 i 0
W 4
L 1 6 3 3 d 1234
R 0 8
W 4
E 0 8 1 1 4
E 3 6 3 3 0
L 0 10 2 3 i 0
W 1
L 0 11 4 5 i 0
W 1
L 0 12 6 7 i 0
W 3
R 0 12
W 2
R 0 10
W 1
R 0 11
W 2
E 0 12 6 7 3
H 5
E 0 10 2 3 7
E 0 11 4 5 7
T 0
L 0 20 1 2 i 0
W 3
L 2 21 1 1 d 55
W 2
T 1
R 0 20
W 2
E 0 20 1 2 6
S 0 0
F 18
W 3
S 2 16
C
S 0 16
K 16
Z
S 0 0

// ==== testbench/tb_rl_trace.sv ====
// Testbench for the remote-load latency monitor
// runs the command list from the data file and drains records over AXI4-Lite
`timescale 1ns/100ps
`default_nettype none

module tb_rl_trace;
  import rl_trace_pkg::*;

  logic                     clk_i;
  logic                     reset_i;
  logic                     out_v_i;
  logic [RL_OP_W-1:0]       out_op_i;
  logic [RL_REG_ID_W-1:0]   out_reg_id_i;
  logic [RL_X_W-1:0]        out_x_i;
  logic [RL_Y_W-1:0]        out_y_i;
  logic [31:0]              out_payload_i;
  logic                     returned_v_i;
  logic                     returned_yumi_i;
  logic [RL_REG_ID_W-1:0]   returned_reg_id_i;
  logic [RL_RET_W-1:0]      returned_type_i;
  logic                     trace_en_i;
  logic [RL_CTR_W-1:0]      global_ctr_i;
  logic [RL_AXI_ADDR_W-1:0] s_awaddr_i;
  logic                     s_awvalid_i;
  logic                     s_awready_o;
  logic [31:0]              s_wdata_i;
  logic                     s_wvalid_i;
  logic                     s_wready_o;
  logic [1:0]               s_bresp_o;
  logic                     s_bvalid_o;
  logic                     s_bready_i;
  logic [RL_AXI_ADDR_W-1:0] s_araddr_i;
  logic                     s_arvalid_i;
  logic                     s_arready_o;
  logic [31:0]              s_rdata_o;
  logic [1:0]               s_rresp_o;
  logic                     s_rvalid_o;
  logic                     s_rready_i;

  // launch and return staged here are applied together by the next step
  logic                   st_launch;
  logic [RL_OP_W-1:0]     st_op;
  logic [RL_REG_ID_W-1:0] st_reg;
  logic [RL_X_W-1:0]      st_x;
  logic [RL_Y_W-1:0]      st_y;
  rl_payload_u            st_pay;
  logic [RL_TYPE_W-1:0]   st_kind;
  logic                   st_ret;
  logic [RL_RET_W-1:0]    st_rtype;
  logic [RL_REG_ID_W-1:0] st_rreg;

  // counter values seen at launch and at return for each class and register
  logic [RL_CTR_W-1:0] launch_ctr [4][RL_REG_ELS];
  logic [RL_CTR_W-1:0] ret_ctr    [3][RL_REG_ELS];

  string          cmds[$];
  int unsigned    limit;
  int             hold_next;

  rl_trace_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    global_ctr_i <= global_ctr_i + 1;
    if (limit != 0 && global_ctr_i > limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", global_ctr_i);
      stop_fail();
    end
  end

  task automatic stop_fail();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      stop_fail();
    end
  endtask

  task automatic compare_record(input logic [RL_TYPE_W-1:0] kind,
                                input logic [RL_REG_ID_W-1:0] rg,
                                input logic [RL_X_W-1:0] x, input logic [RL_Y_W-1:0] y,
                                input logic [RL_CTR_W-1:0] lat,
                                input logic [RL_TYPE_W-1:0] e_kind,
                                input logic [RL_REG_ID_W-1:0] e_rg,
                                input logic [RL_X_W-1:0] e_x, input logic [RL_Y_W-1:0] e_y,
                                input logic [RL_CTR_W-1:0] e_lat);
    compare_word("record kind", 32'(kind), 32'(e_kind));
    compare_word("record reg_id", 32'(rg), 32'(e_rg));
    compare_word("record x", 32'(x), 32'(e_x));
    compare_word("record y", 32'(y), 32'(e_y));
    compare_word("record latency", lat, e_lat);
  endtask

  // launch class derived from op and load info bits
  function automatic logic [RL_TYPE_W-1:0] launch_class(input logic [RL_OP_W-1:0] op,
                                                         input rl_payload_u pay);
    if (op == RL_OP_STORE || op == RL_OP_SW) return RL_TYPE_STORE;
    if (op == RL_OP_LOAD && pay.load_info.icache_fetch) return RL_TYPE_ICACHE;
    if (op == RL_OP_LOAD && pay.load_info.float_wb) return RL_TYPE_FLOAT;
    return RL_TYPE_INT;
  endfunction

  task automatic step();
    @(posedge clk_i);
    out_v_i           <= st_launch;
    out_op_i          <= st_op;
    out_reg_id_i      <= st_reg;
    out_x_i           <= st_x;
    out_y_i           <= st_y;
    out_payload_i     <= st_pay;
    returned_v_i      <= st_ret;
    returned_yumi_i   <= st_ret;
    returned_type_i   <= st_rtype;
    returned_reg_id_i <= st_rreg;
    @(negedge clk_i);
    if (st_launch) begin
      launch_ctr[st_kind][(st_kind == RL_TYPE_ICACHE) ? 0 : st_reg] = global_ctr_i;
    end
    if (st_ret) begin
      ret_ctr[st_rtype][(st_rtype == RL_RET_IFETCH) ? 0 : st_rreg] = global_ctr_i;
    end
    st_launch = 1'b0;
    st_ret    = 1'b0;
  endtask

  task automatic read_reg(input logic [RL_AXI_ADDR_W-1:0] addr, input int hold,
                          output logic [31:0] data);
    @(posedge clk_i);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    s_rready_i  <= (hold == 0);
    @(negedge clk_i);
    compare_word("s_arready_o", 32'(s_arready_o), 32'd1);
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    do @(negedge clk_i); while (!s_rvalid_o);
    data = s_rdata_o;
    compare_word("s_rresp_o", 32'(s_rresp_o), 32'd0);
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_i);
      if (!s_rvalid_o) begin
        $display("read response vanished while rready was held low");
        stop_fail();
      end
      compare_word("s_rdata_o under back-pressure", s_rdata_o, data);
    end
    if (hold != 0) begin
      @(posedge clk_i);
      s_rready_i <= 1'b1;
    end
  endtask

  task automatic clear_drops();
    @(posedge clk_i);
    s_awaddr_i  <= RL_REG_STATUS;
    s_awvalid_i <= 1'b1;
    s_wvalid_i  <= 1'b1;
    @(negedge clk_i);
    compare_word("s_awready_o", 32'(s_awready_o), 32'd1);
    compare_word("s_wready_o", 32'(s_wready_o), 32'd1);
    @(posedge clk_i);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    do @(negedge clk_i); while (!s_bvalid_o);
    compare_word("s_bresp_o", 32'(s_bresp_o), 32'd0);
  endtask

  // start and latency are read first because the info read pops the record
  task automatic drain_record(input int hold, output logic [31:0] start,
                              output logic [31:0] lat, output logic [31:0] info);
    read_reg(RL_REG_START, 0, start);
    read_reg(RL_REG_LATENCY, 0, lat);
    read_reg(RL_REG_INFO, hold, info);
  endtask

  task automatic check_expected(input string line);
    byte         c;
    int          kind;
    int          rg;
    int          x;
    int          y;
    int          lat;
    int          slot;
    logic [31:0] s;
    logic [31:0] l;
    logic [31:0] info;
    void'($sscanf(line, "%c %d %d %d %d %d", c, kind, rg, x, y, lat));
    drain_record(hold_next, s, l, info);
    hold_next = 0;
    compare_record(info[1:0], info[6:2], info[13:8], info[20:16], l,
                   kind[1:0], rg[4:0], x[5:0], y[4:0], lat);
    slot = (kind == RL_TYPE_ICACHE) ? 0 : rg;
    if (kind != RL_TYPE_STORE) begin
      compare_word("latency cross-check", l, ret_ctr[kind][slot] - launch_ctr[kind][slot]);
    end
    compare_word("record start", s, launch_ctr[kind][slot]);
  endtask

  task automatic run_command(input string line);
    byte         c;
    byte         view;
    int          a;
    int          b;
    int          x;
    int          y;
    logic [31:0] val;
    logic [31:0] w;
    logic [31:0] s;
    logic [31:0] l;
    c = line[0];
    case (c)
      "L": begin
        void'($sscanf(line, "%c %d %d %d %d %c %h", c, a, b, x, y, view, val));
        if (view == "i") begin
          st_pay = '0;
          st_pay.load_info.float_wb     = val[1];
          st_pay.load_info.icache_fetch = val[0];
        end else begin
          st_pay.store_data = val;
        end
        st_launch = 1'b1;
        st_op     = a[1:0];
        st_reg    = b[4:0];
        st_x      = x[5:0];
        st_y      = y[4:0];
        st_kind   = launch_class(st_op, st_pay);
      end
      "R": begin
        void'($sscanf(line, "%c %d %d", c, a, b));
        st_ret   = 1'b1;
        st_rtype = a[1:0];
        st_rreg  = b[4:0];
      end
      "W": begin
        void'($sscanf(line, "%c %d", c, a));
        repeat (a) step();
      end
      "T": begin
        void'($sscanf(line, "%c %d", c, a));
        @(posedge clk_i);
        trace_en_i <= a[0];
      end
      "H": void'($sscanf(line, "%c %d", c, hold_next));
      "E": check_expected(line);
      "S": begin
        void'($sscanf(line, "%c %d %d", c, a, b));
        read_reg(RL_REG_STATUS, 0, w);
        compare_word("status", w, {a[15:0], 11'b0, b[4:0]});
      end
      "C": clear_drops();
      "Z": begin
        read_reg(RL_REG_INFO, 0, w);
        compare_word("info of empty FIFO", w, 32'd0);
      end
      "F": begin
        void'($sscanf(line, "%c %d", c, a));
        for (int i = 0; i < a; i++) begin
          st_launch         = 1'b1;
          st_op             = RL_OP_STORE;
          st_reg            = i[4:0];
          st_x              = 6'd1;
          st_y              = 5'd1;
          st_pay.store_data = 32'(i);
          st_kind           = RL_TYPE_STORE;
          step();
        end
      end
      "K": begin
        void'($sscanf(line, "%c %d", c, a));
        for (int i = 0; i < a; i++) begin
          drain_record(0, s, l, w);
          compare_record(w[1:0], w[6:2], w[13:8], w[20:16], l,
                         RL_TYPE_STORE, i[4:0], 6'd1, 5'd1, 32'd0);
          compare_word("record start", s, launch_ctr[RL_TYPE_STORE][i]);
        end
      end
      default: begin
        $display("unknown command in test data: %s", line);
        stop_fail();
      end
    endcase
  endtask

  initial begin
    int    fd;
    int    n;
    byte   c;
    string line;
    reset_i = 1'b1;
    out_v_i = 1'b0;
    out_op_i = '0;
    out_reg_id_i = '0;
    out_x_i = '0;
    out_y_i = '0;
    out_payload_i = '0;
    returned_v_i = 1'b0;
    returned_yumi_i = 1'b0;
    returned_reg_id_i = '0;
    returned_type_i = RL_RET_NONE;
    trace_en_i = 1'b0;
    global_ctr_i = '0;
    s_awaddr_i = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i = '0;
    s_wvalid_i = 1'b0;
    s_bready_i = 1'b1;
    s_araddr_i = '0;
    s_arvalid_i = 1'b0;
    s_rready_i = 1'b1;
    st_launch = 1'b0;
    st_ret = 1'b0;
    st_pay = '0;
    hold_next = 0;
    limit = 0;
    fd = $fopen("testbench/rl_trace_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      stop_fail();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") cmds.push_back(line);
    end
    $fclose(fd);
    // timeout budget covers every wait and fill cycle and about 12 cycles per drained record
    n = 0;
    foreach (cmds[i]) begin
      void'($sscanf(cmds[i], "%c %d", c, n));
      limit += 40;
      if (c == "W" || c == "F" || c == "H") limit += n;
      if (c == "K") limit += 12 * n;
    end
    limit += 10;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    foreach (cmds[i]) run_command(cmds[i]);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
